// ==== compile.f ====
+incdir+verilog
verilog/sifhPkg.sv
verilog/histBus.sv
verilog/dataFilter.sv
verilog/histBuilder.sv
verilog/peakDetector.sv
verilog/windowCalc.sv
verilog/sifhTop.sv
tests/sifh_chk.sv
tests/sifhTb.sv

// ==== tests/sifhTb.sv ====
// Peak finder testbench with file-driven frames, LFSR noise and result checks
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module sifhTb;
    import sifhPkg::*;

    logic                      clk;
    logic                      combin_res;
    logic                      wrEn;
    sample_t                   data;
    logic [`NP*`PIXEL_NUM-1:0] result;
    logic                      resultValid;
    logic                      finePass;

    logic [31:0] lfsr;
    int          errors = 0;
    int          testErrors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    sample_t     frameData[$];     // One pass worth of samples

    sifhTop u_dut (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .data(data),
        .result(result), .resultValid(resultValid), .finePass(finePass)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ********************
    // Helpers
    // ********************
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic drawBits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[6:0], lfsr[0]};    // One LFSR step per bit
            lfsr = lfsrNext(lfsr);
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1 wrEn = 1'b0;
        end
    endtask

    // Noise lands in a different coarse bin from the peak
    task automatic drawNoise(input sample_t peak, output sample_t val);
        val = peak ^ 8'h80;     // Fallback with a different top nibble
        for (int t = 0; t < 64; t++) begin
            logic [7:0] v;
            drawBits(8, v);
            if (v[7:4] != peak[7:4]) begin
                val = v;
                break;
            end
        end
    endtask

    task automatic runPass(input logic expFine, input int gap);
        logic [7:0] g;
        foreach (frameData[i]) begin
            @(posedge clk);
            #1;
            wrEn = 1'b1;
            data = frameData[i];
            checkValue("finePass", finePass, expFine);
            // Gaps only between samples of the pass
            if (gap != 0 && i < frameData.size() - 1) begin
                drawBits(2, g);
                idleCycles(g);
            end
        end
    endtask

    task automatic waitResult(output bit seen);
        seen = 1'b0;
        for (int c = 0; c < 50 && !seen; c++) begin
            @(posedge clk);
            #1 wrEn = 1'b0;
            seen = resultValid;
        end
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (testErrors != 0)
            testsFailed++;
        $display("%-10s %s, %0d errors", name, (testErrors == 0) ? "ok" : "failed", testErrors);
        testErrors = 0;
    endtask

    // ********************
    // Main sequence
    // ********************
    initial begin
        int      fd;
        int      n;
        int      noise;
        int      gap;
        bit      seen;
        string   line;
        string   name;
        sample_t peaks[`PIXEL_NUM];
        sample_t exps[`PIXEL_NUM];
        sample_t v;

        combin_res = 1'b0;
        wrEn       = 1'b0;
        data       = '0;
        lfsr       = 32'h981b0162;
        repeat (3) @(posedge clk);
        #1 combin_res = 1'b1;

        checkValue("resultValid", resultValid, 0);
        checkValue("result", result, 0);
        endTest("reset");

        fd = $fopen("tests/sifh_input.txt", "r");
        if (fd == 0) begin
            $display("Error: stimulus file tests/sifh_input.txt could not be opened");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() == 0 || line[0] == "#")
                    continue;
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %d %d", name,
                            peaks[0], peaks[1], peaks[2], peaks[3],
                            exps[0], exps[1], exps[2], exps[3], noise, gap);
                if (n != 11)
                    continue;   // Blank or short line

                // Acquisition outer, pixel middle, sample inner
                frameData.delete();
                for (int a = 0; a < `ACQ_NUM; a++)
                    for (int p = 0; p < `PIXEL_NUM; p++)
                        for (int k = 0; k < `DATA_NUM; k++) begin
                            if (k < 3 || noise == 0)
                                v = peaks[p];
                            else
                                drawNoise(peaks[p], v);
                            frameData.push_back(v);
                        end

                runPass(1'b0, gap);
                idleCycles(4);
                runPass(1'b1, gap);
                waitResult(seen);
                if (!seen) begin
                    $display("Error: %s timed out waiting for resultValid", name);
                    errors++;
                    testErrors++;
                end else begin
                    for (int p = 0; p < `PIXEL_NUM; p++)
                        checkValue($sformatf("result[%0d]", p), result[p*`NP +: `NP], exps[p]);
                end
                endTest(name);
            end
            $fclose(fd);
        end

        errors += u_dut.u_chk.assertFails;
        $display("Tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 testsRun, testsFailed, errors, u_dut.u_chk.assertFails);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/sifh_chk.sv ====
// Bound assertions on the histogram bus and the result strobe
`timescale 1ns/1ps

module sifh_chk (
    input logic                clk,
    input logic                combin_res,
    input logic                upd,
    input sifhPkg::count_t     binCount,
    input logic                passEnd,
    input sifhPkg::passState_t pass,
    input logic                resultValid
);
    import sifhPkg::*;

    int assertFails = 0;    // Read by the testbench at the end

    // Result strobe lasts one cycle
    singleStrobe: assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |=> !resultValid)
        else begin $error("resultValid high in two consecutive cycles"); assertFails++; end

    // A written bin holds at least one count
    updCount: assert property (@(posedge clk) disable iff (!combin_res)
        upd |-> (binCount != '0))
        else begin $error("zero binCount on an update"); assertFails++; end

    // Only the end of a fine pass produces a result
    fineResult: assert property (@(posedge clk) disable iff (!combin_res)
        (passEnd && pass == PASS_FINE) |-> ##2 resultValid)
        else begin $error("no resultValid after fine pass end"); assertFails++; end

    coarseQuiet: assert property (@(posedge clk) disable iff (!combin_res)
        (passEnd && pass == PASS_COARSE) |-> ##2 !resultValid)
        else begin $error("resultValid after coarse pass end"); assertFails++; end

endmodule

bind sifhTop sifh_chk u_chk (
    .clk(clk), .combin_res(combin_res), .upd(hist.upd), .binCount(hist.binCount),
    .passEnd(hist.passEnd), .pass(pass), .resultValid(resultValid)
);

// ==== tests/sifh_input.txt ====
# name  peak0 peak1 peak2 peak3  exp0 exp1 exp2 exp3  noise gap
# peaks and expected results in hex, noise and gap flags are 0 or 1
mid      40 7a 95 c3  40 7a 95 c3  0 0
low      03 05 00 07  03 05 00 07  0 0
high     fc f0 ff e8  fc f0 ff e8  0 0
clampMix 00 ff 08 f8  00 ff 08 f8  0 0
noise    58 a1 2d e6  58 a1 2d e6  1 0
noiseLo  02 11 1f 6b  02 11 1f 6b  1 0
noiseHi  f3 e1 ef d0  f3 e1 ef d0  1 0
gapA     33 9c 0f f7  33 9c 0f f7  1 1
gapB     c8 17 70 2b  c8 17 70 2b  1 1
gapC     64 64 b5 80  64 64 b5 80  0 1

// ==== verilog/dataFilter.sv ====
// Data filter mapping a timestamp to a bin address with window test
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module dataFilter (
    input  sifhPkg::sample_t    data,
    input  sifhPkg::passState_t pass,
    input  sifhPkg::pixelIdx_t  pixel,
    input  sifhPkg::sampleArr_t winBase,
    output sifhPkg::binAddr_t   bin,
    output logic                inWindow
);
    import sifhPkg::*;

    sample_t base;      // Window base of the current pixel
    sample_t offset;    // Distance from base, wraps when below

    assign base   = winBase[pixel];
    assign offset = data - base;

    // ********************
    // Bin select
    // ********************
    always_comb begin
        if (pass == PASS_COARSE) begin
            // Top bits only, every sample counts
            bin      = {1'b0, data[`NP-1 -: `NB]};
            inWindow = 1'b1;
        end else begin
            // Full resolution relative to the window base
            bin      = offset[`NB:0];
            // Base never exceeds 256 - BIN_NUM so the upper edge cannot wrap
            inWindow = (data >= base) && (offset < `BIN_NUM);
        end
    end

endmodule

// ==== verilog/histBuilder.sv ====
// Histogram builder: bin memory, lazy clear, counters and pass sequencing
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module histBuilder (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                wrEn,
    input  sifhPkg::binAddr_t   bin,
    input  logic                inWindow,
    output sifhPkg::pixelIdx_t  pixel,
    output sifhPkg::passState_t pass,
    histBus.builder             hist
);
    import sifhPkg::*;

    count_t                                 mem [`PIXEL_NUM*`BIN_NUM];
    logic [`PIXEL_NUM*`BIN_NUM-1:0]         valid;     // Bin holds a count of this pass
    logic [$clog2(`PIXEL_NUM*`BIN_NUM)-1:0] addr;
    logic [$clog2(`DATA_NUM)-1:0]           sampleCnt;
    logic [$clog2(`ACQ_NUM)-1:0]            acqCnt;
    logic                                   write;
    logic                                   lastSample;
    logic                                   clearPend;  // passEnd delayed by one cycle
    count_t                                 newCount;

    assign addr  = {pixel, bin};
    assign write = wrEn & inWindow;

    // A stale bin reads as zero
    assign newCount = valid[addr] ? mem[addr] + 1'b1 : count_t'(1);

    assign lastSample = wrEn && (sampleCnt == `DATA_NUM - 1) &&
                        (pixel == `PIXEL_NUM - 1) && (acqCnt == `ACQ_NUM - 1);

    // ********************
    // Nested sample counters
    // ********************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixel     <= '0;
            acqCnt    <= '0;
        end else if (wrEn) begin
            if (sampleCnt == `DATA_NUM - 1) begin
                sampleCnt <= '0;
                if (pixel == `PIXEL_NUM - 1) begin
                    pixel  <= '0;
                    acqCnt <= (acqCnt == `ACQ_NUM - 1) ? '0 : acqCnt + 1'b1;
                end else begin
                    pixel <= pixel + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // ********************
    // Valid vector and pass
    // ********************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hist.upd     <= 1'b0;
            hist.passEnd <= 1'b0;
            clearPend    <= 1'b0;
            pass         <= PASS_COARSE;
            valid        <= '0;
        end else begin
            hist.upd     <= write;          // Dropped samples send no update
            hist.passEnd <= lastSample;
            clearPend    <= hist.passEnd;
            if (clearPend) begin
                // Flash clear, detector has taken its last update
                valid <= '0;
                pass  <= (pass == PASS_COARSE) ? PASS_FINE : PASS_COARSE;
            end else if (write) begin
                valid[addr] <= 1'b1;
            end
        end
    end

    // Memory write and the count sent downstream
    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr]     <= newCount;
            hist.pixel    <= pixel;
            hist.bin      <= bin;
            hist.binCount <= newCount;
        end
    end

endmodule

// ==== verilog/histBus.sv ====
// Histogram update bus from the builder to the peak detector
`timescale 1ns/1ps

interface histBus;
    import sifhPkg::*;

    logic      upd;         // One bin was written
    pixelIdx_t pixel;       // Pixel of the written bin
    binAddr_t  bin;         // Bin just written
    count_t    binCount;    // New count of that bin
    logic      passEnd;     // Last sample of the pass

    // Builder drives everything
    modport builder (
        output upd, pixel, bin, binCount, passEnd
    );

    // Detector only listens
    modport detector (
        input upd, pixel, bin, binCount, passEnd
    );

endinterface

// ==== verilog/peakDetector.sv ====
// Peak detector keeping the running maximum and its bin per pixel
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module peakDetector (
    input  logic             clk,
    input  logic             combin_res,
    histBus.detector         hist,
    output sifhPkg::binArr_t peakBin,
    output logic             peakPassEnd
);
    import sifhPkg::*;

    count_t [`PIXEL_NUM-1:0] maxCnt;   // Highest count seen so far

    logic newMax;

    // Strictly greater, the earliest bin to reach a count keeps it
    assign newMax = hist.upd && (hist.binCount > maxCnt[hist.pixel]);

    // ********************
    // Running maximum
    // ********************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            maxCnt      <= '0;
            peakBin     <= '0;
            peakPassEnd <= 1'b0;
        end else begin
            peakPassEnd <= hist.passEnd;    // peakBin is final in this cycle
            if (peakPassEnd) begin
                // Window stage latches now, start the next pass fresh
                maxCnt <= '0;
            end else if (newMax) begin
                maxCnt[hist.pixel]  <= hist.binCount;
                peakBin[hist.pixel] <= hist.bin;
            end
        end
    end

endmodule

// ==== verilog/sifhPkg.sv ====
// Pass-state enum and shared data types for the peak finder
`include "sifh_cfg.svh"

package sifhPkg;

    // Histogram pass currently running
    typedef enum logic {
        PASS_COARSE = 1'b0,
        PASS_FINE   = 1'b1
    } passState_t;

    typedef logic [`NP-1:0] sample_t;       // Timestamp or window base
    typedef logic [`NB:0]   binAddr_t;      // Bin index inside one pixel
    typedef logic [1:0]     pixelIdx_t;     // Pixel number
    typedef logic [`PEAK_MAX-1:0] count_t;  // Bin count

    // One entry per pixel
    typedef sample_t  [`PIXEL_NUM-1:0] sampleArr_t;
    typedef binAddr_t [`PIXEL_NUM-1:0] binArr_t;

endpackage

// ==== verilog/sifhTop.sv ====
// Top level of the two-pass peak finder
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module sifhTop (
    input  logic                      clk,
    input  logic                      combin_res,
    input  logic                      wrEn,
    input  sifhPkg::sample_t          data,
    output logic [`NP*`PIXEL_NUM-1:0] result,
    output logic                      resultValid,
    output logic                      finePass
);
    import sifhPkg::*;

    binAddr_t   bin;
    logic       inWindow;
    pixelIdx_t  pixel;
    passState_t pass;
    binArr_t    peakBin;
    logic       peakPassEnd;
    sampleArr_t winBase;        // Fed back from the window stage

    histBus hist ();

    dataFilter u_dataFilter (
        .data(data), .pass(pass), .pixel(pixel), .winBase(winBase),
        .bin(bin), .inWindow(inWindow)
    );

    histBuilder u_histBuilder (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .bin(bin),
        .inWindow(inWindow), .pixel(pixel), .pass(pass), .hist(hist.builder)
    );

    peakDetector u_peakDetector (
        .clk(clk), .combin_res(combin_res), .hist(hist.detector),
        .peakBin(peakBin), .peakPassEnd(peakPassEnd)
    );

    windowCalc u_windowCalc (
        .clk(clk), .combin_res(combin_res), .peakBin(peakBin),
        .peakPassEnd(peakPassEnd), .pass(pass), .winBase(winBase),
        .result(result), .resultValid(resultValid)
    );

    assign finePass = (pass == PASS_FINE);

endmodule

// ==== verilog/sifh_cfg.svh ====
// Size macros for the two-pass histogram peak finder
`ifndef SIFH_CFG_SVH
`define SIFH_CFG_SVH

// ********************
// Sample and bin widths
// ********************
`define NP 8            // Timestamp width
`define NB 4            // Coarse bin width
`define BIN_NUM 32      // Bins per pixel histogram, 2**(NB+1)

// ********************
// Frame organisation
// ********************
`define PIXEL_NUM 4     // Pixels per frame
`define DATA_NUM 4      // Samples per pixel per acquisition
`define ACQ_NUM 2       // Acquisitions per pass

// Bin counter width, must hold
// every sample of one pixel in one pass
`define PEAK_MAX 4

`endif

// ==== verilog/windowCalc.sv ====
// Window calculation for the fine pass and final per-pixel results
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module windowCalc (
    input  logic                          clk,
    input  logic                          combin_res,
    input  sifhPkg::binArr_t              peakBin,
    input  logic                          peakPassEnd,
    input  sifhPkg::passState_t           pass,
    output sifhPkg::sampleArr_t           winBase,
    output logic [`NP*`PIXEL_NUM-1:0]     result,
    output logic                          resultValid
);
    import sifhPkg::*;

    logic signed [`NP+1:0] rawBase [`PIXEL_NUM];    // Unclamped, may go negative
    sampleArr_t            nextBase;

    // ********************
    // Window rule
    // ********************
    always_comb begin
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            // Coarse bin back to timestamp scale, half a coarse bin below
            rawBase[p] = ($signed({1'b0, peakBin[p]}) <<< (`NP - `NB)) - 8;
            if (rawBase[p] < 0) begin
                nextBase[p] = '0;
            end else if (rawBase[p] > (2**`NP - `BIN_NUM)) begin
                nextBase[p] = sample_t'(2**`NP - `BIN_NUM);  // Keep window inside range
            end else begin
                nextBase[p] = rawBase[p][`NP-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            winBase     <= '0;
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            if (peakPassEnd) begin
                if (pass == PASS_COARSE) begin
                    winBase <= nextBase;
                end else begin
                    // Fine bin is relative to the base
                    for (int p = 0; p < `PIXEL_NUM; p++) begin
                        result[p*`NP +: `NP] <= winBase[p] + sample_t'(peakBin[p]);
                    end
                    resultValid <= 1'b1;
                end
            end
        end
    end

endmodule
